// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////////////////////////
    // instruction word fields
    ////////////////////////////////////////////////////////////
    localparam int INST_W    = 32;
    localparam int OPCODE_W  = 6;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int FUNCT_W   = 6;
    localparam int IMM_W     = 16;

    localparam int REG_COUNT = 32;
    localparam int LINK_REG  = 31; // highest gpr index

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000, // r-type, decoded by funct
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000, // no overflow trap
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010, // no overflow trap
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

endpackage

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUBU = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_SLL  = 4'd9,
        ALU_SRL  = 4'd10,
        ALU_SRA  = 4'd11,
        ALU_LU   = 4'd12  // load upper
    } alu_op_e;

    typedef enum logic {
        B_REG = 1'b0, // second operand from rt
        B_IMM = 1'b1  // second operand from imm
    } b_src_e;

endpackage

`default_nettype wire

// File: src/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               inst_valid,
    input  isa_pkg::inst_t     raw_inst,
    output logic               dec_valid,
    output isa_pkg::reg_idx_t  rs_idx,
    output logic               rs_enable,
    output isa_pkg::reg_idx_t  rt_idx,
    output logic               rt_enable,
    output isa_pkg::reg_idx_t  rd_idx,
    output logic               wb_en,
    output core_pkg::alu_op_e  alu_op,
    output core_pkg::b_src_e   b_ctrl,
    output core_pkg::word_t    imm,
    output logic               dec_illegal
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_e            op;
    funct_e             funct;
    reg_idx_t           rs_f;
    reg_idx_t           rt_f;
    reg_idx_t           rd_f;
    logic [SHAMT_W-1:0] shamt_f;
    logic [IMM_W-1:0]   imm_f;
    word_t              imm_sext;
    word_t              imm_zext;

    reg_idx_t n_rs;
    reg_idx_t n_rt;
    reg_idx_t n_rd;
    logic     n_rs_en;
    logic     n_rt_en;
    logic     n_wb_en;
    logic     n_illegal;
    alu_op_e  n_op;
    b_src_e   n_b;
    word_t    n_imm;

    assign op       = opcode_e'(raw_inst[31:26]);
    assign rs_f     = raw_inst[25:21];
    assign rt_f     = raw_inst[20:16];
    assign rd_f     = raw_inst[15:11];
    assign shamt_f  = raw_inst[10:6];
    assign funct    = funct_e'(raw_inst[5:0]);
    assign imm_f    = raw_inst[15:0];
    assign imm_sext = word_t'($signed(imm_f));
    assign imm_zext = word_t'(imm_f);

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        n_rs      = '0;
        n_rs_en   = 1'b0;
        n_rt      = '0;
        n_rt_en   = 1'b0;
        n_rd      = '0;
        n_wb_en   = 1'b0;
        n_op      = ALU_NOP;
        n_b       = B_REG;
        n_imm     = '0;
        n_illegal = 1'b0;
        if (raw_inst != '0) begin // zero word falls through as nop
            n_rs    = rs_f;
            n_rs_en = 1'b1;
            n_wb_en = 1'b1;
            if (op == OP_SPECIAL) begin
                n_rt    = rt_f;
                n_rt_en = 1'b1;
                n_rd    = rd_f;
            end else begin
                n_rd = rt_f; // i-type target
                n_b  = B_IMM;
            end
            case (op)
                OP_SPECIAL: begin
                    case (funct)
                        FN_SLL, FN_SLLV: n_op = ALU_SLL;
                        FN_SRL, FN_SRLV: n_op = ALU_SRL;
                        FN_SRA, FN_SRAV: n_op = ALU_SRA;
                        FN_ADD, FN_ADDU: n_op = ALU_ADDU;
                        FN_SUB, FN_SUBU: n_op = ALU_SUBU;
                        FN_AND:          n_op = ALU_AND;
                        FN_OR:           n_op = ALU_OR;
                        FN_XOR:          n_op = ALU_XOR;
                        FN_NOR:          n_op = ALU_NOR;
                        FN_SLT:          n_op = ALU_SLT;
                        FN_SLTU:         n_op = ALU_SLTU;
                        default:         n_illegal = 1'b1;
                    endcase
                    case (funct)
                        FN_SLL, FN_SRL, FN_SRA: begin
                            n_rs    = rt_f; // value to shift
                            n_rt    = '0;
                            n_rt_en = 1'b0;
                            n_b     = B_IMM;
                            n_imm   = word_t'(shamt_f);
                        end
                        FN_SLLV, FN_SRLV, FN_SRAV: begin
                            n_rs = rt_f; // swapped slots
                            n_rt = rs_f;
                        end
                        default: ;
                    endcase
                end
                OP_ADDI, OP_ADDIU: begin
                    n_op  = ALU_ADDU;
                    n_imm = imm_sext;
                end
                OP_SLTI: begin
                    n_op  = ALU_SLT;
                    n_imm = imm_sext;
                end
                OP_SLTIU: begin
                    n_op  = ALU_SLTU;
                    n_imm = imm_sext;
                end
                OP_ANDI: begin
                    n_op  = ALU_AND;
                    n_imm = imm_zext;
                end
                OP_ORI: begin
                    n_op  = ALU_OR;
                    n_imm = imm_zext;
                end
                OP_XORI: begin
                    n_op  = ALU_XOR;
                    n_imm = imm_zext;
                end
                OP_LUI: begin
                    n_rs    = '0;
                    n_rs_en = 1'b0;
                    n_op    = ALU_LU;
                    n_imm   = imm_zext;
                end
                default: n_illegal = 1'b1;
            endcase
            if (n_illegal) begin
                n_rs_en = 1'b0;
                n_rt_en = 1'b0;
                n_wb_en = 1'b0;
                n_op    = ALU_NOP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid   <= 1'b0;
            rs_idx      <= '0;
            rs_enable   <= 1'b0;
            rt_idx      <= '0;
            rt_enable   <= 1'b0;
            rd_idx      <= '0;
            wb_en       <= 1'b0;
            alu_op      <= ALU_NOP;
            b_ctrl      <= B_REG;
            imm         <= '0;
            dec_illegal <= 1'b0;
        end else if (!stall) begin
            dec_valid   <= inst_valid;
            rs_idx      <= n_rs;
            rs_enable   <= n_rs_en;
            rt_idx      <= n_rt;
            rt_enable   <= n_rt_en;
            rd_idx      <= n_rd;
            wb_en       <= inst_valid & n_wb_en;
            alu_op      <= n_op;
            b_ctrl      <= n_b;
            imm         <= n_imm;
            dec_illegal <= inst_valid & n_illegal;
        end
    end

    // a decoded word is never both a write and an illegal
    a_dec_excl: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> !(dec_illegal && wb_en));

endmodule

`default_nettype wire

// File: src/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               dec_valid,
    input  isa_pkg::reg_idx_t  rs_idx,
    input  logic               rs_enable,
    input  isa_pkg::reg_idx_t  rt_idx,
    input  logic               rt_enable,
    input  isa_pkg::reg_idx_t  rd_idx,
    input  logic               wb_en,
    input  core_pkg::alu_op_e  alu_op,
    input  core_pkg::b_src_e   b_ctrl,
    input  core_pkg::word_t    imm,
    input  logic               dec_illegal,
    input  core_pkg::word_t    rs_data,
    input  core_pkg::word_t    rt_data,
    output logic               ex_valid,
    output isa_pkg::reg_idx_t  ex_rd,
    output logic               ex_wb_en,
    output core_pkg::word_t    ex_result,
    output logic               ex_illegal
);
    import isa_pkg::*;
    import core_pkg::*;

    logic       ex_live;
    logic       fwd_rs;
    logic       fwd_rt;
    word_t      a_val;
    word_t      rt_val;
    word_t      b_val;
    logic [4:0] shamt;
    word_t      alu_y;

    ////////////////////////////////////////////////////////////
    // operand select with forwarding
    ////////////////////////////////////////////////////////////
    assign ex_live = ex_valid && ex_wb_en; // older result still in flight
    assign fwd_rs  = ex_live && rs_enable && (rs_idx != '0) && (rs_idx == ex_rd);
    assign fwd_rt  = ex_live && rt_enable && (rt_idx != '0) && (rt_idx == ex_rd);
    assign a_val   = fwd_rs ? ex_result : rs_data;
    assign rt_val  = fwd_rt ? ex_result : rt_data;
    assign b_val   = (b_ctrl == B_IMM) ? imm : rt_val;
    assign shamt   = b_val[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADDU: alu_y = a_val + b_val;
            ALU_SUBU: alu_y = a_val - b_val;
            ALU_AND:  alu_y = a_val & b_val;
            ALU_OR:   alu_y = a_val | b_val;
            ALU_XOR:  alu_y = a_val ^ b_val;
            ALU_NOR:  alu_y = ~(a_val | b_val);
            ALU_SLT:  alu_y = word_t'($signed(a_val) < $signed(b_val));
            ALU_SLTU: alu_y = word_t'(a_val < b_val);
            ALU_SLL:  alu_y = a_val << shamt;
            ALU_SRL:  alu_y = a_val >> shamt;
            ALU_SRA:  alu_y = $signed(a_val) >>> shamt; // sign fill
            ALU_LU:   alu_y = {b_val[15:0], 16'h0000};
            default:  alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_rd      <= '0;
            ex_wb_en   <= 1'b0;
            ex_result  <= '0;
            ex_illegal <= 1'b0;
        end else if (!stall) begin
            ex_valid   <= dec_valid;
            ex_rd      <= rd_idx;
            ex_wb_en   <= wb_en;
            ex_result  <= alu_y;
            ex_illegal <= dec_illegal;
        end
    end

    a_nop_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && wb_en |-> alu_op != ALU_NOP);

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  isa_pkg::reg_idx_t  wr_idx,
    input  core_pkg::word_t    wr_data,
    input  isa_pkg::reg_idx_t  rs_idx,
    input  isa_pkg::reg_idx_t  rt_idx,
    output core_pkg::word_t    rs_data,
    output core_pkg::word_t    rt_data
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t regs [REG_COUNT];

    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && (idx == wr_idx)) begin
            return wr_data; // write-through
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

endmodule

`default_nettype wire

// File: src/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               ex_valid,
    input  isa_pkg::reg_idx_t  ex_rd,
    input  logic               ex_wb_en,
    input  core_pkg::word_t    ex_result,
    input  logic               ex_illegal,
    output logic               wr_en,
    output isa_pkg::reg_idx_t  wr_idx,
    output core_pkg::word_t    wr_data,
    output logic               wb_valid,
    output isa_pkg::reg_idx_t  wb_reg,
    output core_pkg::word_t    wb_data,
    output logic               illegal_inst
);
    import isa_pkg::*;
    import core_pkg::*;

    assign wr_en   = ex_valid && ex_wb_en && !stall; // commit on advancing edge
    assign wr_idx  = ex_rd;
    assign wr_data = ex_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_reg       <= '0;
            wb_data      <= '0;
            illegal_inst <= 1'b0;
        end else begin
            wb_valid     <= wr_en; // nop gives no pulse
            illegal_inst <= ex_valid && ex_illegal && !stall;
            if (wr_en) begin
                wb_reg  <= ex_rd;
                wb_data <= ex_result;
            end
        end
    end

    a_report_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && illegal_inst));

endmodule

`default_nettype wire

// File: src/alu_core.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               inst_valid,
    input  isa_pkg::inst_t     raw_inst,
    output logic               wb_valid,
    output isa_pkg::reg_idx_t  wb_reg,
    output core_pkg::word_t    wb_data,
    output logic               illegal_inst
);
    import isa_pkg::*;
    import core_pkg::*;

    // decode -> execute
    logic     dec_valid;
    reg_idx_t rs_idx;
    logic     rs_enable;
    reg_idx_t rt_idx;
    logic     rt_enable;
    reg_idx_t rd_idx;
    logic     wb_en;
    alu_op_e  alu_op;
    b_src_e   b_ctrl;
    word_t    imm;
    logic     dec_illegal;

    // execute -> result
    logic     ex_valid;
    reg_idx_t ex_rd;
    logic     ex_wb_en;
    word_t    ex_result;
    logic     ex_illegal;

    // register file ports
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    word_t    rs_data;
    word_t    rt_data;

    inst_decoder decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .inst_valid  (inst_valid),
        .raw_inst    (raw_inst),
        .dec_valid   (dec_valid),
        .rs_idx      (rs_idx),
        .rs_enable   (rs_enable),
        .rt_idx      (rt_idx),
        .rt_enable   (rt_enable),
        .rd_idx      (rd_idx),
        .wb_en       (wb_en),
        .alu_op      (alu_op),
        .b_ctrl      (b_ctrl),
        .imm         (imm),
        .dec_illegal (dec_illegal)
    );

    alu_execute execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .rs_idx      (rs_idx),
        .rs_enable   (rs_enable),
        .rt_idx      (rt_idx),
        .rt_enable   (rt_enable),
        .rd_idx      (rd_idx),
        .wb_en       (wb_en),
        .alu_op      (alu_op),
        .b_ctrl      (b_ctrl),
        .imm         (imm),
        .dec_illegal (dec_illegal),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_wb_en    (ex_wb_en),
        .ex_result   (ex_result),
        .ex_illegal  (ex_illegal)
    );

    reg_file regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    result_stage result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_wb_en     (ex_wb_en),
        .ex_result    (ex_result),
        .ex_illegal   (ex_illegal),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .illegal_inst (illegal_inst)
    );

endmodule

`default_nettype wire

// File: sim/alu_core_vectors.svh
`ifndef ALU_CORE_VECTORS_SVH
`define ALU_CORE_VECTORS_SVH

// each row holds the instruction word, a report flag (0 for no report),
// the write register, the value written and the illegal flag
// registers start at zero after reset

localparam int VEC_COUNT = 40;

localparam vec_t VECTORS [VEC_COUNT] = '{
    '{32'h3C011234, 1'b1, 5'd1,  32'h12340000, 1'b0}, // lui r1
    '{32'h34215678, 1'b1, 5'd1,  32'h12345678, 1'b0}, // ori r1, r1
    '{32'h2402FFFD, 1'b1, 5'd2,  32'hFFFFFFFD, 1'b0}, // addiu sign extends
    '{32'h3403FFFD, 1'b1, 5'd3,  32'h0000FFFD, 1'b0}, // ori zero extends
    '{32'h20040064, 1'b1, 5'd4,  32'h00000064, 1'b0}, // addi
    '{32'h00242821, 1'b1, 5'd5,  32'h123456DC, 1'b0}, // addu
    '{32'h00823023, 1'b1, 5'd6,  32'h00000067, 1'b0}, // subu
    '{32'h00433820, 1'b1, 5'd7,  32'h0000FFFA, 1'b0}, // add wraps
    '{32'h00644022, 1'b1, 5'd8,  32'h0000FF99, 1'b0}, // sub
    '{32'h00234824, 1'b1, 5'd9,  32'h00005678, 1'b0}, // and
    '{32'h00445025, 1'b1, 5'd10, 32'hFFFFFFFD, 1'b0}, // or
    '{32'h00235826, 1'b1, 5'd11, 32'h1234A985, 1'b0}, // xor
    '{32'h00836027, 1'b1, 5'd12, 32'hFFFF0002, 1'b0}, // nor
    '{32'h0044682A, 1'b1, 5'd13, 32'h00000001, 1'b0}, // slt -3 < 100
    '{32'h0044702B, 1'b1, 5'd14, 32'h00000000, 1'b0}, // sltu same pair
    '{32'h284FFFFF, 1'b1, 5'd15, 32'h00000001, 1'b0}, // slti
    '{32'h2C90FFFF, 1'b1, 5'd16, 32'h00000001, 1'b0}, // sltiu
    '{32'h3051FF00, 1'b1, 5'd17, 32'h0000FF00, 1'b0}, // andi
    '{32'h3832FFFF, 1'b1, 5'd18, 32'h1234A987, 1'b0}, // xori
    '{32'h00019900, 1'b1, 5'd19, 32'h23456780, 1'b0}, // sll 4
    '{32'h0002A202, 1'b1, 5'd20, 32'h00FFFFFF, 1'b0}, // srl 8
    '{32'h0002AA03, 1'b1, 5'd21, 32'hFFFFFFFF, 1'b0}, // sra 8 fills ones
    '{32'h0081B004, 1'b1, 5'd22, 32'h23456780, 1'b0}, // sllv by r4
    '{32'h0082B806, 1'b1, 5'd23, 32'h0FFFFFFF, 1'b0}, // srlv
    '{32'h0082C007, 1'b1, 5'd24, 32'hFFFFFFFF, 1'b0}, // srav
    '{32'h24190007, 1'b1, 5'd25, 32'h00000007, 1'b0}, // addiu r25
    '{32'h0339C821, 1'b1, 5'd25, 32'h0000000E, 1'b0}, // r25 + r25 back to back
    '{32'h0339D021, 1'b1, 5'd26, 32'h0000001C, 1'b0},
    '{32'h033AD821, 1'b1, 5'd27, 32'h0000002A, 1'b0}, // r26 forwarded and r25 two apart
    '{32'h24000005, 1'b1, 5'd0,  32'h00000005, 1'b0}, // write to r0 still reports
    '{32'h0000E021, 1'b1, 5'd28, 32'h00000000, 1'b0}, // r0 reads zero
    '{32'h341D0011, 1'b1, 5'd29, 32'h00000011, 1'b0},
    '{32'h00000000, 1'b0, 5'd0,  32'h00000000, 1'b0}, // nop
    '{32'hFC1D1234, 1'b0, 5'd0,  32'h00000000, 1'b1}, // unknown opcode
    '{32'h0021E83F, 1'b0, 5'd0,  32'h00000000, 1'b1}, // unknown funct
    '{32'h03A0F021, 1'b1, 5'd30, 32'h00000011, 1'b0}, // r29 untouched
    '{32'h00000000, 1'b0, 5'd0,  32'h00000000, 1'b0}, // nop
    '{32'h03D3F823, 1'b1, 5'd31, 32'hDCBA9891, 1'b0}, // subu goes negative
    '{32'h001F0FC3, 1'b1, 5'd1,  32'hFFFFFFFF, 1'b0}, // sra 31
    '{32'h001F17C2, 1'b1, 5'd2,  32'h00000001, 1'b0}  // srl 31
};

`endif

// File: sim/alu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_tb;

    typedef struct packed {
        logic [31:0] inst;
        logic        reports; // low for nop
        logic [4:0]  rd;
        logic [31:0] value;
        logic        illegal;
    } vec_t;

    `include "alu_core_vectors.svh"

    localparam int TIMEOUT_CYCLES = 4 * VEC_COUNT + 50;
    localparam int DRIVE_DELAY    = 2;
    localparam int DRAIN_LIMIT    = 8; // three-cycle latency plus slack

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        inst_valid;
    logic [31:0] raw_inst;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        illegal_inst;

    vec_t expect_q [$];
    int   cycle_count = 0;

    alu_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .inst_valid   (inst_valid),
        .raw_inst     (raw_inst),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .illegal_inst (illegal_inst)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // failure handling
    ////////////////////////////////////////////////////////////
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        int idx;
        int drain_cycles;
        idx = 0;
        drain_cycles = 0;
        void'($urandom(32'h43a7f4d5));
        rst_n      = 1'b0;
        stall      = 1'b0;
        inst_valid = 1'b0;
        raw_inst   = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        while (idx < VEC_COUNT) begin
            if (($urandom % 4) == 0) begin
                stall      = 1'b1; // frozen cycle with nothing offered
                inst_valid = 1'b0;
            end else begin
                stall      = 1'b0;
                inst_valid = 1'b1;
                raw_inst   = VECTORS[idx].inst;
                if (VECTORS[idx].reports || VECTORS[idx].illegal) begin
                    expect_q.push_back(VECTORS[idx]);
                end
                idx++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        stall      = 1'b0;
        inst_valid = 1'b0;
        raw_inst   = '0;
        while ((expect_q.size() != 0) && (drain_cycles < DRAIN_LIMIT)) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (4) @(posedge clk); // room for a stray report
        if (expect_q.size() != 0) begin
            fail_run($sformatf("%0d expected reports never arrived", expect_q.size()));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // monitor and scoreboard
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin : monitor_blk
        vec_t exp_entry;
        if ((rst_n === 1'b1) && (wb_valid || illegal_inst)) begin
            if (expect_q.size() == 0) begin
                fail_run("a report came out with no instruction outstanding");
            end else begin
                exp_entry = expect_q.pop_front();
                check_value("illegal_inst", 32'(illegal_inst), 32'(exp_entry.illegal));
                check_value("wb_valid", 32'(wb_valid), 32'(!exp_entry.illegal));
                if (!exp_entry.illegal) begin
                    check_value("wb_reg", 32'(wb_reg), 32'(exp_entry.rd));
                    check_value("wb_data", wb_data, exp_entry.value);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, pipeline did not drain",
                               TIMEOUT_CYCLES));
        end
    end

endmodule

`default_nettype wire

// File: alu_core.f
+incdir+sim
src/isa_pkg.sv
src/core_pkg.sv
src/inst_decoder.sv
src/alu_execute.sv
src/reg_file.sv
src/result_stage.sv
src/alu_core.sv
sim/alu_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := alu_core_tb
FILELIST  := alu_core.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
